// File: tb.f
verilog/pi1_pkg.sv
verilog/pi1_master_arbiter.sv
verilog/pi1_slave_decoder.sv
verilog/pi1_interconnect.sv
verilog/pi1_ram_slave.sv
verilog/pi1_default_slave.sv
verilog/pi1_subsystem_top.sv
sim/pi1_checker.sv
sim/tb_pi1.sv

// File: Makefile
# Verilator build and run of the PI1 subsystem testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_pi1 and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_pi1 -Mdir obj_dir -f tb.f
	./obj_dir/Vtb_pi1 > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// File: sim/tb_pi1.sv
// PI1 subsystem testbench
// Two table-driven masters, bus checker, watchdog and closing report
`timescale 1ns/1ps

module tb_pi1 import pi1_pkg::*; ();

	localparam int MASTER_COUNT = 2;
	localparam int SLAVE_COUNT  = 3;
	localparam int RAM0_WORDS   = 64;
	localparam int RAM1_WORDS   = 32;

	typedef struct packed {
		logic              mst;
		pi1_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [ARCH_W-1:0] data;
		logic [SEL_W-1:0]  sel;
		logic [ARCH_W-1:0] exp;    // Read value known from this master's own writes
		logic              chk;
	} entry_t;

	logic              clk = 1'b0;
	logic              rst = 1'b1;
	pi1_req_t          m_req [MASTER_COUNT];
	pi1_rsp_t          m_rsp [MASTER_COUNT];
	logic              exp_chk [MASTER_COUNT];
	logic [ARCH_W-1:0] exp_data [MASTER_COUNT];
	entry_t            tbl [$];
	int                seed = 32'h2538;
	int                data_err;
	int                hs_err;
	int                rd_cnt;

	always #5 clk = ~clk;

	pi1_subsystem_top #(
		.MASTER_COUNT (MASTER_COUNT),
		.SLAVE_COUNT  (SLAVE_COUNT),
		.RAM0_WORDS   (RAM0_WORDS),
		.RAM1_WORDS   (RAM1_WORDS)
	) uut (
		.clk_i   (clk),
		.rst_i   (rst),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp)
	);

	pi1_checker #(
		.MASTER_COUNT (MASTER_COUNT),
		.SLAVE_COUNT  (SLAVE_COUNT),
		.MAPPED_WORDS (RAM0_WORDS + RAM1_WORDS)
	) u_checker (
		.clk_i      (clk),
		.rst_i      (rst),
		.m_req_i    (m_req),
		.m_rsp_i    (m_rsp),
		.exp_chk_i  (exp_chk),
		.exp_data_i (exp_data),
		.data_err_o (data_err),
		.hs_err_o   (hs_err),
		.rd_cnt_o   (rd_cnt)
	);

	function automatic entry_t make_entry(input int m, input pi1_op_e op, input int unsigned addr,
		input logic [ARCH_W-1:0] data, input logic [SEL_W-1:0] sel,
		input logic [ARCH_W-1:0] exp, input logic chk);
		entry_t e;
		e.mst  = 1'(m);
		e.op   = op;
		e.addr = ADDR_W'(addr);
		e.data = data;
		e.sel  = sel;
		e.exp  = exp;
		e.chk  = chk;
		return e;
	endfunction

	task automatic load_tables();
		tbl.push_back(make_entry(0, PI1_WR, 0, 32'h1111_1111, 4'hf, '0, 1'b0));
		tbl.push_back(make_entry(1, PI1_WR, 20, 32'h2020_2020, 4'hf, '0, 1'b0));
		tbl.push_back(make_entry(0, PI1_WR, 64, 32'hA5A5_0064, 4'hf, '0, 1'b0));
		tbl.push_back(make_entry(1, PI1_WR, 70, 32'h7070_7070, 4'hf, '0, 1'b0));
		tbl.push_back(make_entry(0, PI1_RD, 0, '0, 4'h0, 32'h1111_1111, 1'b1));
		tbl.push_back(make_entry(1, PI1_RD, 200, '0, 4'h0, '0, 1'b0));    // Unmapped
		tbl.push_back(make_entry(0, PI1_RD, 64, '0, 4'h0, 32'hA5A5_0064, 1'b1));
		tbl.push_back(make_entry(1, PI1_WR, 70, 32'hDEAD_BEEF, 4'h3, '0, 1'b0));
		tbl.push_back(make_entry(0, PI1_WR, 0, 32'hFFEE_DDCC, 4'h5, '0, 1'b0));
		tbl.push_back(make_entry(1, PI1_RD, 70, '0, 4'h0, 32'h7070_BEEF, 1'b1));
		tbl.push_back(make_entry(0, PI1_RD, 0, '0, 4'h0, 32'h11EE_11CC, 1'b1));
		tbl.push_back(make_entry(1, PI1_RW, 20, 32'h0BAD_C0DE, 4'hf, 32'h2020_2020, 1'b1));
		tbl.push_back(make_entry(0, PI1_WR, 63, 32'h6363_6363, 4'hf, '0, 1'b0));
		tbl.push_back(make_entry(1, PI1_RD, 20, '0, 4'h0, 32'h0BAD_C0DE, 1'b1));
		tbl.push_back(make_entry(0, PI1_WR, 95, 32'h9595_9595, 4'hf, '0, 1'b0));
		tbl.push_back(make_entry(1, PI1_RD, 97, '0, 4'h0, '0, 1'b0));
		tbl.push_back(make_entry(0, PI1_RD, 63, '0, 4'h0, 32'h6363_6363, 1'b1));
		tbl.push_back(make_entry(1, PI1_RD, 70, '0, 4'h0, 32'h7070_BEEF, 1'b1));
		tbl.push_back(make_entry(0, PI1_RD, 95, '0, 4'h0, 32'h9595_9595, 1'b1));
		tbl.push_back(make_entry(1, PI1_RW, 300, 32'h0000_0300, 4'hf, '0, 1'b0));
		tbl.push_back(make_entry(0, PI1_RW, 64, 32'hCAFE_F00D, 4'hf, 32'hA5A5_0064, 1'b1));
		tbl.push_back(make_entry(0, PI1_RD, 64, '0, 4'h0, 32'hCAFE_F00D, 1'b1));
		tbl.push_back(make_entry(0, PI1_WR, 96, 32'h0000_0096, 4'hf, '0, 1'b0));
		tbl.push_back(make_entry(0, PI1_RD, 150, '0, 4'h0, '0, 1'b0));
		tbl.push_back(make_entry(0, PI1_WR, 95, 32'h1234_5678, 4'ha, '0, 1'b0));
		tbl.push_back(make_entry(0, PI1_RD, 95, '0, 4'h0, 32'h1295_5695, 1'b1));
	endtask

	// Holds each request until rdy, then idles for a cycle
	task automatic run_master(input int m);
		pi1_req_t req;
		int       gap;
		for (int k = 0; k < tbl.size(); k++) begin
			if (tbl[k].mst == 1'(m)) begin
				req.op   = tbl[k].op;
				req.addr = tbl[k].addr;
				req.data = tbl[k].data;
				req.sel  = tbl[k].sel;
				gap = $unsigned($random(seed)) % 3;
				repeat (gap) @(posedge clk);
				@(posedge clk);
				m_req[m] <= req;
				do @(posedge clk); while (m_rsp[m].rdy !== 1'b1);
				req.op = PI1_NOOP;
				m_req[m]    <= req;
				exp_chk[m]  <= tbl[k].chk;
				exp_data[m] <= tbl[k].exp;
			end
		end
	endtask

	initial begin
		repeat (10) @(posedge clk);
		rst <= 1'b0;
	end

	initial begin
		for (int m = 0; m < MASTER_COUNT; m++) begin
			m_req[m]    = '0;
			exp_chk[m]  = 1'b0;
			exp_data[m] = '0;
		end
		load_tables();
		fork
			run_master(0);
			run_master(1);
		join
		repeat (4) @(posedge clk);
		$display("Report: %0d data errors, %0d handshake errors, %0d reads",
			data_err, hs_err, rd_cnt);
		if (data_err + hs_err == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#1;
		repeat (tbl.size() * 200) @(posedge clk);
		$display("Watchdog expired after %0d cycles with requests still outstanding",
			tbl.size() * 200);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: sim/pi1_checker.sv
// PI1 bus checker
// Follows accepted requests on the master ports against a memory and miss-count model
`timescale 1ns/1ps

module pi1_checker import pi1_pkg::*; #(
	parameter int MASTER_COUNT = 2,
	parameter int SLAVE_COUNT  = 3,
	parameter int MAPPED_WORDS = 96
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  pi1_req_t          m_req_i [MASTER_COUNT],
	input  pi1_rsp_t          m_rsp_i [MASTER_COUNT],
	input  logic              exp_chk_i [MASTER_COUNT],
	input  logic [ARCH_W-1:0] exp_data_i [MASTER_COUNT],
	output int                data_err_o,
	output int                hs_err_o,
	output int                rd_cnt_o
);

	logic [ARCH_W-1:0] mem [int unsigned];    // Both RAMs, keyed by bus word address
	logic [ARCH_W-1:0] miss_cnt;
	logic [ARCH_W-1:0] pend_exp;
	logic              pend = 1'b0;
	int                pend_m = 0;
	int                since_rst = 0;
	int                data_err = 0;
	int                hs_err = 0;
	int                rd_cnt = 0;

	assign data_err_o = data_err;
	assign hs_err_o   = hs_err;
	assign rd_cnt_o   = rd_cnt;

	function automatic logic [ARCH_W-1:0] merge_bytes(input logic [ARCH_W-1:0] old,
		input logic [ARCH_W-1:0] data, input logic [SEL_W-1:0] sel);
		logic [ARCH_W-1:0] v;
		v = old;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b])
				v[b*8 +: 8] = data[b*8 +: 8];
		end
		return v;
	endfunction

	always @(posedge clk_i) begin
		pi1_req_t          r;
		int unsigned       a;
		logic [ARCH_W-1:0] old;
		// Read data is due one cycle after acceptance
		if (pend) begin
			rd_cnt++;
			if (m_rsp_i[pend_m].data !== pend_exp) begin
				$display("[FAIL] %0t ns: master %0d read %h, model expects %h",
					$time, pend_m, m_rsp_i[pend_m].data, pend_exp);
				data_err++;
			end
			if (exp_chk_i[pend_m] && m_rsp_i[pend_m].data !== exp_data_i[pend_m]) begin
				$display("[FAIL] %0t ns: master %0d read %h, table expects %h",
					$time, pend_m, m_rsp_i[pend_m].data, exp_data_i[pend_m]);
				data_err++;
			end
		end
		pend = 1'b0;
		if (rst_i) begin
			since_rst = 0;
			miss_cnt  = '0;
		end else if (since_rst < 1000) begin
			since_rst++;
		end
		for (int m = 0; m < MASTER_COUNT; m++) begin
			if (m_rsp_i[m].rdy === 1'b1 && (rst_i || since_rst <= 2 * SLAVE_COUNT)) begin
				$display("Error at %0t ns: master %0d got rdy before the address map was built",
					$time, m);
				hs_err++;
			end else if (m_rsp_i[m].rdy === 1'b1 && m_req_i[m].op != PI1_NOOP) begin
				r = m_req_i[m];
				a = {2'b00, r.addr};
				if (a < MAPPED_WORDS) begin
					old = mem.exists(a) ? mem[a] : 'x;
					if (r.op == PI1_WR || r.op == PI1_RW)
						mem[a] = merge_bytes(old, r.data, r.sel);
				end else begin
					old      = miss_cnt;    // Count from before this access
					miss_cnt = miss_cnt + 32'd1;
				end
				if (r.op == PI1_RD || r.op == PI1_RW) begin
					pend     = 1'b1;
					pend_m   = m;
					pend_exp = old;
				end
			end
		end
	end

endmodule

// File: verilog/pi1_subsystem_top.sv
// PI1 subsystem top level
// Two external masters, interconnect, two RAMs and the default slave
`timescale 1ns/1ps

module pi1_subsystem_top import pi1_pkg::*; #(
	parameter int MASTER_COUNT     = 2,
	parameter int SLAVE_COUNT      = 3,
	parameter int DEFAULT_SLAVE    = 2,
	parameter int FIRST_SLAVE_ADDR = 0,
	parameter int RAM0_WORDS       = 64,
	parameter int RAM1_WORDS       = 32
) (
	input  logic     clk_i,
	input  logic     rst_i,
	input  pi1_req_t m_req_i [MASTER_COUNT],
	output pi1_rsp_t m_rsp_o [MASTER_COUNT]
);

	pi1_req_t          s_req   [SLAVE_COUNT];
	pi1_rsp_t          s_rsp   [SLAVE_COUNT];
	logic [ADDR_W-1:0] s_mapsz [SLAVE_COUNT];

	pi1_interconnect #(
		.MASTER_COUNT     (MASTER_COUNT),
		.SLAVE_COUNT      (SLAVE_COUNT),
		.DEFAULT_SLAVE    (DEFAULT_SLAVE),
		.FIRST_SLAVE_ADDR (FIRST_SLAVE_ADDR)
	) u_interconnect (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.m_req_i   (m_req_i),
		.m_rsp_o   (m_rsp_o),
		.s_req_o   (s_req),
		.s_rsp_i   (s_rsp),
		.s_mapsz_i (s_mapsz)
	);

	// Map order follows slave index
	pi1_ram_slave #(.WORDS(RAM0_WORDS)) u_ram0 (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.req_i   (s_req[0]),
		.rsp_o   (s_rsp[0]),
		.mapsz_o (s_mapsz[0])
	);

	pi1_ram_slave #(.WORDS(RAM1_WORDS)) u_ram1 (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.req_i   (s_req[1]),
		.rsp_o   (s_rsp[1]),
		.mapsz_o (s_mapsz[1])
	);

	pi1_default_slave u_default (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.req_i   (s_req[DEFAULT_SLAVE]),
		.rsp_o   (s_rsp[DEFAULT_SLAVE]),
		.mapsz_o (s_mapsz[DEFAULT_SLAVE])
	);

endmodule

// File: verilog/pi1_default_slave.sv
// PI1 default slave
// Counts accesses that no other slave claims, reads return the count
`timescale 1ns/1ps

module pi1_default_slave import pi1_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_i,
	input  pi1_req_t          req_i,
	output pi1_rsp_t          rsp_o,
	output logic [ADDR_W-1:0] mapsz_o
);

	logic [ARCH_W-1:0] miss_cnt;
	logic [ARCH_W-1:0] rd_q;
	logic              rdy_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			miss_cnt <= '0;
			rdy_q    <= 1'b0;
		end else begin
			rdy_q <= 1'b1;
			if (req_i.op != PI1_NOOP)
				miss_cnt <= miss_cnt + 1'b1;
		end
	end

	// Count before this access
	always_ff @(posedge clk_i) begin
		if (req_i.op == PI1_RD || req_i.op == PI1_RW)
			rd_q <= miss_cnt;
	end

	assign rsp_o.data = rd_q;
	assign rsp_o.rdy  = rdy_q;
	assign mapsz_o    = '0;    // Takes no range, only misses

endmodule

// File: verilog/pi1_ram_slave.sv
// PI1 word RAM slave
// Byte-select writes, registered reads, read-write returns the old word
`timescale 1ns/1ps

module pi1_ram_slave import pi1_pkg::*; #(
	parameter int WORDS = 64,
	localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  pi1_req_t          req_i,
	output pi1_rsp_t          rsp_o,
	output logic [ADDR_W-1:0] mapsz_o
);

	localparam int BYTE_W = ARCH_W / SEL_W;

	logic [ARCH_W-1:0] mem [WORDS];
	logic [ARCH_W-1:0] rd_q;
	logic [AW-1:0]     widx;
	logic              wr_en;
	logic              rd_en;
	logic              rdy_q;

	assign widx  = req_i.addr[AW-1:0];
	assign wr_en = (req_i.op == PI1_WR) || (req_i.op == PI1_RW);
	assign rd_en = (req_i.op == PI1_RD) || (req_i.op == PI1_RW);

	always_ff @(posedge clk_i) begin
		if (rd_en)
			rd_q <= mem[widx];    // Old word on read-write
		if (wr_en) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (req_i.sel[b])
					mem[widx][b*BYTE_W +: BYTE_W] <= req_i.data[b*BYTE_W +: BYTE_W];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			rdy_q <= 1'b0;
		else
			rdy_q <= 1'b1;
	end

	assign rsp_o.data = rd_q;
	assign rsp_o.rdy  = rdy_q;
	assign mapsz_o    = ADDR_W'(WORDS);

endmodule

// File: verilog/pi1_interconnect.sv
// PI1 interconnect
// Arbitrates masters, routes to the decoded slave with a relative address, returns read data
`timescale 1ns/1ps

module pi1_interconnect import pi1_pkg::*; #(
	parameter int MASTER_COUNT     = 2,
	parameter int SLAVE_COUNT      = 3,
	parameter int DEFAULT_SLAVE    = 2,
	parameter int FIRST_SLAVE_ADDR = 0,
	localparam int MIDX_W = (MASTER_COUNT > 1) ? $clog2(MASTER_COUNT) : 1,
	localparam int SIDX_W = (SLAVE_COUNT > 1) ? $clog2(SLAVE_COUNT) : 1
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  pi1_req_t          m_req_i [MASTER_COUNT],
	output pi1_rsp_t          m_rsp_o [MASTER_COUNT],
	output pi1_req_t          s_req_o [SLAVE_COUNT],
	input  pi1_rsp_t          s_rsp_i [SLAVE_COUNT],
	input  logic [ADDR_W-1:0] s_mapsz_i [SLAVE_COUNT]
);

	pi1_op_e           m_ops [MASTER_COUNT];
	pi1_req_t          greq;         // Granted master's request
	logic [MIDX_W-1:0] grant;
	logic [SIDX_W-1:0] sidx;
	logic [SIDX_W-1:0] rd_idx;       // Slave that owes read data
	logic [ADDR_W-1:0] sbase;
	logic              hit;
	logic              rd_pend;
	logic              rd_ret;
	logic              accept;
	logic              rd_acc;
	logic [ARCH_W-1:0] rd_data_q;
	logic [ARCH_W-1:0] rd_data;

	always_comb begin
		for (int i = 0; i < MASTER_COUNT; i++)
			m_ops[i] = m_req_i[i].op;
	end

	pi1_master_arbiter #(
		.MASTER_COUNT (MASTER_COUNT)
	) u_arbiter (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.m_ops_i   (m_ops),
		.m_grant_o (grant)
	);

	assign greq = m_req_i[grant];

	pi1_slave_decoder #(
		.SLAVE_COUNT      (SLAVE_COUNT),
		.DEFAULT_SLAVE    (DEFAULT_SLAVE),
		.FIRST_SLAVE_ADDR (FIRST_SLAVE_ADDR)
	) u_decoder (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.req_op_i     (greq.op),
		.req_addr_i   (greq.addr),
		.mapsz_i      (s_mapsz_i),
		.slave_idx_o  (sidx),
		.slave_base_o (sbase),
		.hit_o        (hit)
	);

	assign rd_ret = rd_pend && s_rsp_i[rd_idx].rdy;
	// A pending read that is not returning yet blocks the next request
	assign accept  = (rd_ret || !rd_pend) && hit && s_rsp_i[sidx].rdy;
	assign rd_acc  = accept && (greq.op == PI1_RD || greq.op == PI1_RW);
	assign rd_data = rd_ret ? s_rsp_i[rd_idx].data : rd_data_q;

	always_ff @(posedge clk_i) begin
		if (rst_i)
			rd_pend <= 1'b0;
		else if (rd_ret || rd_acc)
			rd_pend <= rd_acc;
	end

	always_ff @(posedge clk_i) begin
		if (rd_acc)
			rd_idx <= sidx;
		if (rd_ret)
			rd_data_q <= s_rsp_i[rd_idx].data;    // Keeps data stable afterwards
	end

	always_comb begin
		for (int i = 0; i < MASTER_COUNT; i++) begin
			m_rsp_o[i].data = rd_data;
			m_rsp_o[i].rdy  = accept && (grant == MIDX_W'(i));
		end
		for (int j = 0; j < SLAVE_COUNT; j++) begin
			s_req_o[j].op   = (accept && sidx == SIDX_W'(j)) ? greq.op : PI1_NOOP;
			s_req_o[j].addr = greq.addr - sbase;
			s_req_o[j].data = greq.data;
			s_req_o[j].sel  = greq.sel;
		end
	end

endmodule

// File: verilog/pi1_slave_decoder.sv
// PI1 slave decoder
// Builds the address map from reported sizes, then finds the slave for each address
`timescale 1ns/1ps

module pi1_slave_decoder import pi1_pkg::*; #(
	parameter int SLAVE_COUNT      = 3,
	parameter int DEFAULT_SLAVE    = 2,
	parameter int FIRST_SLAVE_ADDR = 0,
	localparam int SIDX_W = (SLAVE_COUNT > 1) ? $clog2(SLAVE_COUNT) : 1
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  pi1_op_e           req_op_i,
	input  logic [ADDR_W-1:0] req_addr_i,
	input  logic [ADDR_W-1:0] mapsz_i [SLAVE_COUNT],
	output logic [SIDX_W-1:0] slave_idx_o,
	output logic [ADDR_W-1:0] slave_base_o,
	output logic              hit_o
);

	typedef enum logic [1:0] {
		MAP_BUILD,
		SEARCH,
		HIT
	} dec_state_e;

	localparam logic [ADDR_W-1:0] FIRST_ADDR = ADDR_W'(FIRST_SLAVE_ADDR);
	localparam logic [SIDX_W-1:0] LAST_IDX   = SIDX_W'(SLAVE_COUNT - 1);
	localparam logic [SIDX_W-1:0] DFLT_IDX   = SIDX_W'(DEFAULT_SLAVE);

	dec_state_e        state;
	logic [ADDR_W-1:0] end_addr [SLAVE_COUNT];    // Exclusive end of each range
	logic [ADDR_W-1:0] mapsz_q;
	logic [ADDR_W-1:0] end_q;
	logic [ADDR_W-1:0] lo;                        // Base of the slave under test
	logic              busy;                      // Table read in flight
	logic              dflt;                      // Holding a miss on the default slave
	logic              in_range;
	logic              valid;

	assign in_range     = (req_addr_i >= lo) && (req_addr_i < end_q);
	assign valid        = (req_op_i == PI1_NOOP) || (dflt ? (req_addr_i == lo) : in_range);
	assign hit_o        = (state == HIT) && valid;
	assign slave_base_o = lo;

	// Table reads lag slave_idx_o by one cycle
	always_ff @(posedge clk_i) begin
		mapsz_q <= mapsz_i[slave_idx_o];
		end_q   <= end_addr[slave_idx_o];
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state       <= MAP_BUILD;
			slave_idx_o <= '0;
			lo          <= FIRST_ADDR;
			busy        <= 1'b1;
			dflt        <= 1'b0;
		end else if (busy) begin
			busy <= 1'b0;
		end else begin
			case (state)
				MAP_BUILD: begin
					end_addr[slave_idx_o] <= lo + mapsz_q;
					busy <= 1'b1;
					if (slave_idx_o < LAST_IDX) begin
						lo          <= lo + mapsz_q;    // Next slave starts where this ends
						slave_idx_o <= slave_idx_o + 1'b1;
					end else begin
						lo          <= FIRST_ADDR;
						slave_idx_o <= '0;
						state       <= SEARCH;
					end
				end
				SEARCH: begin
					if (valid) begin
						state <= HIT;
					end else if (dflt) begin
						// Address moved before the miss was served
						slave_idx_o <= '0;
						lo          <= FIRST_ADDR;
						dflt        <= 1'b0;
						busy        <= 1'b1;
					end else if (slave_idx_o < LAST_IDX) begin
						lo          <= end_q;
						slave_idx_o <= slave_idx_o + 1'b1;
						busy        <= 1'b1;
					end else begin
						lo          <= req_addr_i;    // Nobody claims it
						slave_idx_o <= DFLT_IDX;
						dflt        <= 1'b1;
						busy        <= 1'b1;
					end
				end
				default: begin
					if (!valid) begin
						state       <= SEARCH;
						slave_idx_o <= '0;
						lo          <= FIRST_ADDR;
						dflt        <= 1'b0;
						busy        <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

// File: verilog/pi1_master_arbiter.sv
// PI1 master arbiter
// Round-robin grant that moves on idle cycles and skips idle high-index masters
`timescale 1ns/1ps

module pi1_master_arbiter import pi1_pkg::*; #(
	parameter int MASTER_COUNT = 2,
	localparam int MIDX_W = (MASTER_COUNT > 1) ? $clog2(MASTER_COUNT) : 1
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  pi1_op_e           m_ops_i [MASTER_COUNT],
	output logic [MIDX_W-1:0] m_grant_o
);

	localparam logic [MIDX_W-1:0] TOP_IDX = MIDX_W'(MASTER_COUNT - 1);

	logic [MIDX_W-1:0] scan_idx;    // Background scanner position
	logic [MIDX_W-1:0] scan_hi;     // Highest active master from the last pass
	logic [MIDX_W-1:0] wrap_idx;    // Wrap point for the current round
	logic              scan_active;

	assign scan_active = (m_ops_i[scan_idx] != PI1_NOOP);

	// Scan downwards, restart from the top on the first active master or at 0
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			scan_idx <= TOP_IDX;
			scan_hi  <= TOP_IDX;
		end else if (scan_active || scan_idx == '0) begin
			if (scan_active)
				scan_hi <= scan_idx;
			scan_idx <= TOP_IDX;
		end else begin
			scan_idx <= scan_idx - 1'b1;
		end
	end

	// Grant only moves while the granted master is idle
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			m_grant_o <= '0;
			wrap_idx  <= TOP_IDX;
		end else if (m_ops_i[m_grant_o] == PI1_NOOP) begin
			if (m_grant_o < wrap_idx) begin
				m_grant_o <= m_grant_o + 1'b1;
			end else begin
				m_grant_o <= '0;
				wrap_idx  <= scan_hi;    // Drops masters that went quiet
			end
		end
	end

endmodule

// File: verilog/pi1_pkg.sv
// PI1 bus definitions shared by the interconnect, the slaves and the top level
// Op encoding, request and response bundles, bus widths
package pi1_pkg;

	localparam int ARCH_W = 32;            // Data word width
	localparam int ADDR_W = ARCH_W - 2;    // Word address
	localparam int SEL_W  = ARCH_W / 8;    // One select bit per byte

	typedef enum logic [1:0] {
		PI1_NOOP = 2'b00,
		PI1_WR   = 2'b01,
		PI1_RD   = 2'b10,
		PI1_RW   = 2'b11    // Write new word, return old word
	} pi1_op_e;

	// Held by the master until rdy is seen on a rising edge
	typedef struct packed {
		pi1_op_e             op;
		logic [ADDR_W-1:0]   addr;
		logic [ARCH_W-1:0]   data;
		logic [SEL_W-1:0]    sel;
	} pi1_req_t;

	typedef struct packed {
		logic [ARCH_W-1:0]   data;
		logic                rdy;
	} pi1_rsp_t;

endpackage
